/* cancid_pkg.sv */
package cancid_pkg;

  // Stream id space
  localparam int STREAM_W = 6;
  localparam int NUM_STREAMS = 2 ** STREAM_W;

  typedef logic [STREAM_W-1:0] stream_id_t;

  // Global match count width
  localparam int COUNT_W = 16;

  // Literal searched for by the DFA
  // First character sits in the top byte
  localparam int PATTERN_LEN = 6;
  localparam logic [8*PATTERN_LEN-1:0] PATTERN = "rlogin";

  // DFA state is the matched prefix length from 0 up to PATTERN_LEN
  typedef logic [2:0] dfa_state_t;

  // Nothing matched yet
  localparam dfa_state_t DFA_IDLE = 3'd0;
  // Whole literal matched
  localparam dfa_state_t DFA_ACCEPT = dfa_state_t'(PATTERN_LEN);

  // One input byte beat of a stream
  typedef struct packed {
    stream_id_t stream_id;
    logic [7:0] char;
    // First beat of a packet
    logic       sop;
    // Last beat of a packet
    logic       eop;
  } char_beat_t;

  // One report per finished packet
  typedef struct packed {
    stream_id_t           stream_id;
    // Stream was enabled at eop
    logic                 enabled;
    // Literal seen in this packet and always 0 when disabled
    logic                 fired;
    // Global count after this packet
    logic [COUNT_W-1:0]   count;
  } report_t;

endpackage

/* stream_ingress.sv */
`timescale 1ns/10ps

module stream_ingress #(
  parameter int IN_DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  cancid_pkg::char_beat_t in_beat,
  output logic                   in_credit,
  input  logic                   space,
  output logic                   beat_valid,
  output cancid_pkg::char_beat_t beat,
  output logic                   new_stream
);

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int FILL_W = $clog2(IN_DEPTH + 1);

  cancid_pkg::char_beat_t fifo_mem [IN_DEPTH];

  logic [PTR_W-1:0]                   wr_ptr;
  logic [PTR_W-1:0]                   rd_ptr;
  logic [FILL_W-1:0]                  fill;
  logic [cancid_pkg::NUM_STREAMS-1:0] seen;
  logic                               full;
  logic                               empty;
  logic                               pop;

  assign empty = (fill == '0);
  assign full = (fill == FILL_W'(IN_DEPTH));

  // Pop only while the report side can still take a report
  assign pop = !empty && space;

  // Head of FIFO is presented directly in show-ahead style
  assign beat_valid = pop;
  assign beat = fifo_mem[rd_ptr];

  // First packet of a stream since reset starts from a clean DFA
  assign new_stream = beat.sop && !seen[beat.stream_id];

  // Beat storage
  always_ff @(posedge clk)
  begin
    if (in_valid)
      fifo_mem[wr_ptr] <= in_beat;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      seen <= '0;
      in_credit <= 1'b0;
    end
    else
    begin
      // Source only sends while holding a credit
      if (in_valid)
        wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (in_valid && !pop)
        fill <= fill + 1'b1;
      else if (!in_valid && pop)
        fill <= fill - 1'b1;
      // One credit back per freed entry
      in_credit <= pop;
      // Mark stream as known once its first packet leaves
      if (pop && beat.sop)
        seen[beat.stream_id] <= 1'b1;
    end
  end

  // Source sent without a credit
  a_no_credit_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) in_valid |-> !full
  );

endmodule

/* rlogin_dfa.sv */
`timescale 1ns/10ps

module rlogin_dfa (
  input  cancid_pkg::dfa_state_t state_in,
  input  logic [7:0]             char_in,
  output cancid_pkg::dfa_state_t state_out,
  output logic                   accept
);

  // First literal character where a mismatch restarts
  localparam logic [7:0] FIRST_CHAR =
    cancid_pkg::PATTERN[8*cancid_pkg::PATTERN_LEN-1 -: 8];

  // Effective prefix length before this character
  cancid_pkg::dfa_state_t step;
  // Character that would extend the prefix
  logic [7:0]             expect_char;

  always_comb
  begin
    // After a full match the next step starts over like idle
    if (state_in == cancid_pkg::DFA_ACCEPT)
      step = cancid_pkg::DFA_IDLE;
    else
      step = state_in;

    // Pattern is stored first character in the top byte
    expect_char = cancid_pkg::PATTERN[8*(cancid_pkg::PATTERN_LEN - 1 - int'(step)) +: 8];

    if (char_in == expect_char)
      state_out = step + 3'd1;
    // A stray 'r' can begin a new match
    else if (char_in == FIRST_CHAR)
      state_out = 3'd1;
    else
      state_out = cancid_pkg::DFA_IDLE;
  end

  // Accept fires on the character that completes the literal
  // No proper prefix of the literal is also a suffix, so a restart
  // never loses a partial match
  assign accept = (state_out == cancid_pkg::DFA_ACCEPT);

endmodule

/* category_matcher.sv */
`timescale 1ns/10ps

module category_matcher (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               beat_valid,
  input  cancid_pkg::char_beat_t             beat,
  input  logic                               new_stream,
  input  logic [cancid_pkg::NUM_STREAMS-1:0] enable_mask,
  output logic                               rpt_push,
  output cancid_pkg::report_t                rpt_data
);

  // Saved DFA state per stream
  cancid_pkg::dfa_state_t state_mem [cancid_pkg::NUM_STREAMS];

  cancid_pkg::dfa_state_t        work_state;
  cancid_pkg::dfa_state_t        start_state;
  cancid_pkg::dfa_state_t        next_state;
  logic                          dfa_accept;
  logic                          spec_flag;
  logic                          fired_next;
  logic                          stream_en;
  logic                          pkt_open;
  logic [cancid_pkg::COUNT_W-1:0] count;
  logic [cancid_pkg::COUNT_W-1:0] count_next;

  // Restore at sop, otherwise continue the running packet
  always_comb
  begin
    if (!beat.sop)
      start_state = work_state;
    else if (new_stream)
      start_state = cancid_pkg::DFA_IDLE;
    else
      start_state = state_mem[beat.stream_id];
  end

  rlogin_dfa i_rlogin_dfa (
    .state_in  (start_state),
    .char_in   (beat.char),
    .state_out (next_state),
    .accept    (dfa_accept)
  );

  // Speculative flag restarts with each packet
  assign fired_next = (beat.sop ? 1'b0 : spec_flag) | dfa_accept;
  assign stream_en = enable_mask[beat.stream_id];
  assign count_next = count + {{(cancid_pkg::COUNT_W - 1){1'b0}}, fired_next};

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      work_state <= cancid_pkg::DFA_IDLE;
      spec_flag <= 1'b0;
      pkt_open <= 1'b0;
      count <= '0;
      rpt_push <= 1'b0;
    end
    else
    begin
      // Report goes out the cycle after eop
      rpt_push <= beat_valid && beat.eop;
      if (beat_valid)
      begin
        work_state <= next_state;
        spec_flag <= fired_next;
        pkt_open <= !beat.eop;
        if (beat.eop)
        begin
          // Only enabled streams commit their flag
          if (stream_en)
            count <= count_next;
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    // Seed a fresh stream so later restores read a defined state
    if (beat_valid && beat.sop && new_stream)
      state_mem[beat.stream_id] <= cancid_pkg::DFA_IDLE;
    // Save state so a match may straddle packets
    // The eop write wins over the seed
    if (beat_valid && beat.eop && stream_en)
      state_mem[beat.stream_id] <= next_state;
    if (beat_valid && beat.eop)
    begin
      rpt_data.stream_id <= beat.stream_id;
      rpt_data.enabled <= stream_en;
      rpt_data.fired <= stream_en & fired_next;
      rpt_data.count <= stream_en ? count_next : count;
    end
  end

  // Packets arrive whole, one after another
  a_no_sop_in_packet: assert property (
    @(posedge clk) disable iff (!rst_n) beat_valid && beat.sop |-> !pkt_open
  );

endmodule

/* match_report.sv */
`timescale 1ns/10ps

module match_report #(
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                rpt_push,
  input  cancid_pkg::report_t rpt_data,
  output logic                space,
  output logic                out_valid,
  output cancid_pkg::report_t out_rpt,
  input  logic                out_credit
);

  localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int FILL_W = $clog2(OUT_DEPTH + 1);
  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  cancid_pkg::report_t fifo_mem [OUT_DEPTH];

  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FILL_W-1:0] fill;
  logic [CRED_W-1:0] credit_cnt;
  logic              full;
  logic              empty;
  logic              pop;

  assign empty = (fill == '0);
  assign full = (fill == FILL_W'(OUT_DEPTH));

  // Room for one more report plus the one already in flight
  assign space = (fill <= FILL_W'(OUT_DEPTH - 2));

  // Send while a report waits and the sink has granted a credit
  assign pop = !empty && (credit_cnt != '0);

  // Report storage and outgoing payload
  always_ff @(posedge clk)
  begin
    if (rpt_push)
      fifo_mem[wr_ptr] <= rpt_data;
    if (pop)
      out_rpt <= fifo_mem[rd_ptr];
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      credit_cnt <= CRED_W'(OUT_CREDITS);
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= pop;
      if (rpt_push)
        wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (rpt_push && !pop)
        fill <= fill + 1'b1;
      else if (!rpt_push && pop)
        fill <= fill - 1'b1;
      // Each send costs one credit and each sink pulse returns one
      if (pop && !out_credit)
        credit_cnt <= credit_cnt - 1'b1;
      else if (!pop && out_credit)
        credit_cnt <= credit_cnt + 1'b1;
    end
  end

  // Matcher pushed past the space signal
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) rpt_push |-> !full
  );

  // Sink never returns more credits than it was granted
  a_no_credit_excess: assert property (
    @(posedge clk) disable iff (!rst_n)
      out_credit && !pop |-> credit_cnt != CRED_W'(OUT_CREDITS)
  );

endmodule

/* cancid_top.sv */
`timescale 1ns/10ps

module cancid_top #(
  parameter int IN_DEPTH    = 8,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               in_valid,
  input  cancid_pkg::char_beat_t             in_beat,
  output logic                               in_credit,
  input  logic [cancid_pkg::NUM_STREAMS-1:0] enable_mask,
  output logic                               out_valid,
  output cancid_pkg::report_t                out_rpt,
  input  logic                               out_credit
);

  // Ingress to matcher
  logic                   beat_valid;
  cancid_pkg::char_beat_t beat;
  logic                   new_stream;
  // Matcher to report side
  logic                   rpt_push;
  cancid_pkg::report_t    rpt_data;
  // Report FIFO back-pressure to ingress
  logic                   space;

  stream_ingress #(
    .IN_DEPTH (IN_DEPTH)
  ) i_stream_ingress (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .space      (space),
    .beat_valid (beat_valid),
    .beat       (beat),
    .new_stream (new_stream)
  );

  category_matcher i_category_matcher (
    .clk         (clk),
    .rst_n       (rst_n),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .new_stream  (new_stream),
    .enable_mask (enable_mask),
    .rpt_push    (rpt_push),
    .rpt_data    (rpt_data)
  );

  match_report #(
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_match_report (
    .clk        (clk),
    .rst_n      (rst_n),
    .rpt_push   (rpt_push),
    .rpt_data   (rpt_data),
    .space      (space),
    .out_valid  (out_valid),
    .out_rpt    (out_rpt),
    .out_credit (out_credit)
  );

endmodule

/* tb_cancid.sv */
`timescale 1ns/10ps

module tb_cancid;

  localparam int IN_DEPTH = 8;
  localparam int OUT_DEPTH = 4;
  localparam int OUT_CREDITS = 2;
  // Upper bound for any wait, in clock cycles
  localparam int WAIT_LIMIT = 2000;

  logic                               clk;
  logic                               rst_n;
  logic                               in_valid;
  cancid_pkg::char_beat_t             in_beat;
  logic                               in_credit;
  logic [cancid_pkg::NUM_STREAMS-1:0] enable_mask;
  logic                               out_valid;
  cancid_pkg::report_t                out_rpt;
  logic                               out_credit;

  // Source side credit bookkeeping
  int beats_sent;
  int credits_back;
  // Sink side credit bookkeeping
  int reports_seen;
  int credits_given;
  int gap_cnt;
  int sink_gap;
  bit sink_hold;

  // Reference model with saved prefix length per stream and the global count
  int saved_state [cancid_pkg::NUM_STREAMS];
  int model_count;
  cancid_pkg::report_t exp_q [$];
  cancid_pkg::report_t got_q [$];

  integer seed = 32'he265;
  int     errors;
  int     checks;
  string  pattern = "rlogin";

  cancid_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_DEPTH   (OUT_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_cancid_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_beat     (in_beat),
    .in_credit   (in_credit),
    .enable_mask (enable_mask),
    .out_valid   (out_valid),
    .out_rpt     (out_rpt),
    .out_credit  (out_credit)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Registered outputs sampled mid-cycle
  always @(negedge clk)
  begin
    if (in_credit)
      credits_back = credits_back + 1;
    if (out_valid)
    begin
      reports_seen = reports_seen + 1;
      got_q.push_back(out_rpt);
    end
  end

  // Sink hands back one credit per report spaced by sink_gap idle cycles
  always @(posedge clk)
  begin
    out_credit <= 1'b0;
    if (gap_cnt > 0)
      gap_cnt = gap_cnt - 1;
    else if (!sink_hold && credits_given < reports_seen)
    begin
      out_credit <= 1'b1;
      credits_given = credits_given + 1;
      gap_cnt = sink_gap;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $finish;
  endtask

  // Prefix length after one more byte
  function automatic int dfa_next(input int state, input byte c);
    int step;
    // A full match restarts like idle
    step = (state == 6) ? 0 : state;
    if (c == pattern[step])
      return step + 1;
    else if (c == "r")
      return 1;
    else
      return 0;
  endfunction

  // Digits only so filler never touches the literal
  function automatic string filler(input int n);
    string s;
    byte   b;
    s = "";
    for (int i = 0; i < n; i++)
    begin
      b = 8'(48 + $unsigned($random(seed)) % 10);
      s = {s, "0"};
      s.putc(i, b);
    end
    return s;
  endfunction

  task automatic send_beat(input cancid_pkg::char_beat_t b);
    int n;
    n = 0;
    @(posedge clk);
    // Hold off while the source has no credit left
    while (IN_DEPTH + credits_back - beats_sent <= 0 && n < WAIT_LIMIT)
    begin
      in_valid <= 1'b0;
      @(posedge clk);
      n++;
    end
    if (n >= WAIT_LIMIT)
      abort_run("timeout waiting for an input credit");
    else
    begin
      in_valid <= 1'b1;
      in_beat <= b;
      beats_sent++;
    end
  endtask

  task automatic send_packet(input int sid, input string s);
    cancid_pkg::char_beat_t b;
    cancid_pkg::report_t    r;
    int                     st;
    bit                     flag;
    st = saved_state[sid];
    flag = 1'b0;
    for (int i = 0; i < s.len(); i++)
    begin
      b.stream_id = cancid_pkg::stream_id_t'(sid);
      b.char = s[i];
      b.sop = (i == 0);
      b.eop = (i == s.len() - 1);
      send_beat(b);
      st = dfa_next(st, s[i]);
      if (st == 6)
        flag = 1'b1;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    // Enabled streams commit flag and state, disabled ones drop both
    if (enable_mask[sid])
    begin
      model_count = model_count + flag;
      saved_state[sid] = st;
    end
    r.stream_id = cancid_pkg::stream_id_t'(sid);
    r.enabled = enable_mask[sid];
    r.fired = enable_mask[sid] & flag;
    r.count = cancid_pkg::COUNT_W'(model_count);
    exp_q.push_back(r);
  endtask

  task automatic expect_report(input bit want_fired);
    cancid_pkg::report_t got;
    cancid_pkg::report_t exp;
    int                  n;
    n = 0;
    while (got_q.size() == 0 && n < WAIT_LIMIT)
    begin
      @(posedge clk);
      n++;
    end
    if (n >= WAIT_LIMIT)
      abort_run("timeout waiting for a report on out_valid");
    else
    begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      checks++;
      if (got != exp || got.fired != want_fired)
      begin
        errors++;
        $display("error at %0t: got stream %0d en %0b fired %0b count %0d, %s %0d %0b %0b %0d",
          $time, got.stream_id, got.enabled, got.fired, got.count, "expected",
          exp.stream_id, exp.enabled, exp.fired, exp.count);
      end
    end
  endtask

  task automatic single_packet_match;
    send_packet(0, {filler(3), "rlogin", filler(2)});
    expect_report(1'b1);
    send_packet(0, filler(6));
    expect_report(1'b0);
  endtask

  // Match straddles packets only within one stream
  task automatic split_across_packets;
    send_packet(5, {filler(2), "rlo"});
    expect_report(1'b0);
    send_packet(5, {"gin", filler(2)});
    expect_report(1'b1);
    send_packet(7, {filler(2), "rlo"});
    expect_report(1'b0);
    send_packet(8, {"gin", filler(2)});
    expect_report(1'b0);
  endtask

  task automatic disabled_stream_drop;
    send_packet(20, {filler(2), "rlogin", filler(2)});
    expect_report(1'b0);
    send_packet(21, {filler(1), "rlo"});
    expect_report(1'b0);
    // Enable only after the first half so nothing was saved to continue from
    @(posedge clk);
    enable_mask[21] <= 1'b1;
    @(posedge clk);
    send_packet(21, {"gin", filler(1)});
    expect_report(1'b0);
  endtask

  task automatic interleaved_streams;
    send_packet(10, {filler(2), "rl"});
    send_packet(11, {filler(1), "rlogin"});
    send_packet(12, {filler(3), "rlog"});
    send_packet(10, {"ogin", filler(2)});
    send_packet(12, {"in", filler(3)});
    send_packet(11, filler(4));
    expect_report(1'b0);
    expect_report(1'b1);
    expect_report(1'b0);
    expect_report(1'b1);
    expect_report(1'b1);
    expect_report(1'b0);
  endtask

  task automatic output_back_pressure;
    int held;
    int n;
    sink_hold = 1'b1;
    fork
      for (int p = 0; p < 8; p++)
        send_packet(30 + p % 4, (p % 2 == 0) ? {filler(2), "rlogin", filler(2)} : filler(10));
      begin
        n = 0;
        // Source spends all its input credits once the report FIFO backs up
        while (beats_sent - credits_back < IN_DEPTH && n < WAIT_LIMIT)
        begin
          @(posedge clk);
          n++;
        end
        if (n >= WAIT_LIMIT)
          abort_run("source never ran out of input credits under back-pressure");
        else
        begin
          held = credits_back;
          repeat (50) @(posedge clk);
          // Ingress stalled and source holds no credit at all
          checks++;
          if (credits_back != held || beats_sent - credits_back != IN_DEPTH)
          begin
            errors++;
            $display("error at %0t: input credits wrong under back-pressure, %0d outstanding",
              $time, beats_sent - credits_back);
          end
          sink_hold = 1'b0;
        end
      end
    join
    for (int p = 0; p < 8; p++)
      expect_report(p % 2 == 0);
  endtask

  initial
  begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_beat = '0;
    out_credit = 1'b0;
    enable_mask = '1;
    enable_mask[23:20] = '0;
    for (int i = 0; i < cancid_pkg::NUM_STREAMS; i++)
      saved_state[i] = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    single_packet_match();
    split_across_packets();
    disabled_stream_drop();
    sink_gap = 3;
    interleaved_streams();
    sink_gap = 0;
    output_back_pressure();
    repeat (20) @(posedge clk);
    // Exactly one report per packet and every input credit returned
    checks++;
    if (got_q.size() != 0 || exp_q.size() != 0 || credits_back != beats_sent)
    begin
      errors++;
      $display("error at %0t: leftover reports or unreturned input credits", $time);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

/* tb.f */
cancid_pkg.sv
stream_ingress.sv
rlogin_dfa.sv
category_matcher.sv
match_report.sv
cancid_top.sv
tb_cancid.sv

/* Bender.yml */
package:
  name: cancid

sources:
  - cancid_pkg.sv
  - stream_ingress.sv
  - rlogin_dfa.sv
  - category_matcher.sv
  - match_report.sv
  - cancid_top.sv
  - target: test
    files:
      - tb_cancid.sv
